// File: include/perf_mon_settings.svh
`ifndef PERF_MON_SETTINGS_SVH
`define PERF_MON_SETTINGS_SVH

// lane counts of the core's valid vectors
`define PERF_FETCH_WIDTH     4
`define PERF_DISPATCH_WIDTH  4
`define PERF_ISSUE_WIDTH     5
`define PERF_COMMIT_WIDTH    4

`define PERF_CTR_WIDTH       32
`define PERF_ADDR_WIDTH      8

// register map
`define PERF_ADDR_CYCLES          8'h00
`define PERF_ADDR_COMMIT_STORE    8'h01
`define PERF_ADDR_COMMIT_LOAD     8'h02
`define PERF_ADDR_RECOVER         8'h03
`define PERF_ADDR_LOAD_VIOL       8'h04
`define PERF_ADDR_TOTAL_COMMIT    8'h05
`define PERF_ADDR_FS1_FS2         8'h30
`define PERF_ADDR_FS2_DEC         8'h31
`define PERF_ADDR_REN_DIS         8'h32
`define PERF_ADDR_IQ_REG_READ     8'h35
`define PERF_ADDR_FETCH1_STALL    8'h40
`define PERF_ADDR_FREELIST_STALL  8'h43
`define PERF_ADDR_IQ_STALL        8'h47
`define PERF_ADDR_ROB_STALL       8'h48
`define PERF_ADDR_INST_MISS       8'h50
`define PERF_ADDR_LOAD_MISS       8'h51
`define PERF_ADDR_STORE_MISS      8'h52

`define PERF_UNMAPPED_DATA        'h55

`endif

// File: src/perf_mon_pkg.sv
`include "perf_mon_settings.svh"

package perf_mon_pkg;

  // one entry per kept counter, CTR_COUNT closes the list
  typedef enum logic [4:0]
  {
    CTR_CYCLES,
    CTR_COMMIT_STORE,
    CTR_COMMIT_LOAD,
    CTR_RECOVER,
    CTR_LOAD_VIOL,
    CTR_TOTAL_COMMIT,
    CTR_FS1_FS2,
    CTR_FS2_DEC,
    CTR_REN_DIS,
    CTR_IQ_REG_READ,
    CTR_FETCH1_STALL,
    CTR_FREELIST_STALL,
    CTR_IQ_STALL,
    CTR_ROB_STALL,
    CTR_INST_MISS,
    CTR_LOAD_MISS,
    CTR_STORE_MISS,
    CTR_COUNT
  } perf_ctr_idx_t;

  localparam int NUM_CTRS = int'(CTR_COUNT);

  typedef logic [`PERF_CTR_WIDTH-1:0] perf_ctr_t;

  // holds the set-bit count of the widest lane vector
  typedef logic [2:0] perf_incr_t;

  typedef perf_incr_t [NUM_CTRS-1:0] perf_incr_vec_t;

  typedef logic [`PERF_FETCH_WIDTH-1:0]    fetch_lanes_t;
  typedef logic [`PERF_DISPATCH_WIDTH-1:0] dispatch_lanes_t;
  typedef logic [`PERF_ISSUE_WIDTH-1:0]    issue_lanes_t;
  typedef logic [`PERF_COMMIT_WIDTH-1:0]   commit_lanes_t;

endpackage

// File: src/perf_event_if.sv
// one sampled cycle, sampler to counter bank and readout
interface perf_event_if;

  perf_mon_pkg::perf_incr_vec_t incr;
  logic                         run;
  logic                         global_clr;
  logic                         clr_hit;
  perf_mon_pkg::perf_ctr_idx_t  sel_idx;
  logic                         sel_valid;

  modport sampler
  (
    output incr, run, global_clr, clr_hit, sel_idx, sel_valid
  );

  modport bank
  (
    input incr, run, global_clr, clr_hit, sel_idx, sel_valid
  );

  // readout only needs the decoded address
  modport reader
  (
    input sel_idx, sel_valid
  );

endinterface

// File: src/perf_event_sampler.sv
`include "perf_mon_settings.svh"

module perf_event_sampler import perf_mon_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic [`PERF_ADDR_WIDTH-1:0] addr_i,
  input  logic                        run_i,
  input  logic                        clr_i,
  input  logic                        global_clr_i,
  input  commit_lanes_t               commit_store_i,
  input  commit_lanes_t               commit_load_i,
  input  commit_lanes_t               total_commit_i,
  input  fetch_lanes_t                fs1_fs2_valid_i,
  input  fetch_lanes_t                fs2_dec_valid_i,
  input  dispatch_lanes_t             ren_dis_valid_i,
  input  issue_lanes_t                iq_reg_read_valid_i,
  input  logic                        recover_i,
  input  logic                        load_violation_i,
  input  logic                        fetch1_stall_i,
  input  logic                        freelist_stall_i,
  input  logic                        iq_stall_i,
  input  logic                        rob_stall_i,
  input  logic                        inst_miss_i,
  input  logic                        load_miss_i,
  input  logic                        store_miss_i,
  perf_event_if.sampler               ev_o
);

  localparam int MAX_FD = (`PERF_FETCH_WIDTH > `PERF_DISPATCH_WIDTH) ?
                          `PERF_FETCH_WIDTH : `PERF_DISPATCH_WIDTH;
  localparam int MAX_IC = (`PERF_ISSUE_WIDTH > `PERF_COMMIT_WIDTH) ?
                          `PERF_ISSUE_WIDTH : `PERF_COMMIT_WIDTH;
  localparam int MAX_LANES = (MAX_FD > MAX_IC) ? MAX_FD : MAX_IC;

  perf_incr_vec_t incr_d;
  perf_ctr_idx_t  dec_idx;
  logic           dec_valid;

  function automatic perf_incr_t count_ones(input logic [MAX_LANES-1:0] lanes);
    perf_incr_t n;
    n = '0;
    for (int i = 0; i < MAX_LANES; i++)
    begin
      n = n + perf_incr_t'(lanes[i]);
    end
    return n;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // per-cycle increments
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    incr_d                     = '0;
    incr_d[CTR_CYCLES]         = perf_incr_t'(1);
    incr_d[CTR_COMMIT_STORE]   = count_ones(MAX_LANES'(commit_store_i));
    incr_d[CTR_COMMIT_LOAD]    = count_ones(MAX_LANES'(commit_load_i));
    incr_d[CTR_TOTAL_COMMIT]   = count_ones(MAX_LANES'(total_commit_i));
    incr_d[CTR_RECOVER]        = perf_incr_t'(recover_i);
    incr_d[CTR_LOAD_VIOL]      = perf_incr_t'(load_violation_i);
    incr_d[CTR_FS1_FS2]        = count_ones(MAX_LANES'(fs1_fs2_valid_i));
    incr_d[CTR_FS2_DEC]        = count_ones(MAX_LANES'(fs2_dec_valid_i));
    incr_d[CTR_REN_DIS]        = count_ones(MAX_LANES'(ren_dis_valid_i));
    incr_d[CTR_IQ_REG_READ]    = count_ones(MAX_LANES'(iq_reg_read_valid_i));
    incr_d[CTR_FETCH1_STALL]   = perf_incr_t'(fetch1_stall_i);
    incr_d[CTR_FREELIST_STALL] = perf_incr_t'(freelist_stall_i);
    incr_d[CTR_IQ_STALL]       = perf_incr_t'(iq_stall_i);
    incr_d[CTR_ROB_STALL]      = perf_incr_t'(rob_stall_i);
    incr_d[CTR_INST_MISS]      = perf_incr_t'(inst_miss_i);
    incr_d[CTR_LOAD_MISS]      = perf_incr_t'(load_miss_i);
    incr_d[CTR_STORE_MISS]     = perf_incr_t'(store_miss_i);
  end

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    dec_valid = 1'b1;
    dec_idx   = CTR_CYCLES;
    case (addr_i)
      `PERF_ADDR_CYCLES:         dec_idx = CTR_CYCLES;
      `PERF_ADDR_COMMIT_STORE:   dec_idx = CTR_COMMIT_STORE;
      `PERF_ADDR_COMMIT_LOAD:    dec_idx = CTR_COMMIT_LOAD;
      `PERF_ADDR_RECOVER:        dec_idx = CTR_RECOVER;
      `PERF_ADDR_LOAD_VIOL:      dec_idx = CTR_LOAD_VIOL;
      `PERF_ADDR_TOTAL_COMMIT:   dec_idx = CTR_TOTAL_COMMIT;
      `PERF_ADDR_FS1_FS2:        dec_idx = CTR_FS1_FS2;
      `PERF_ADDR_FS2_DEC:        dec_idx = CTR_FS2_DEC;
      `PERF_ADDR_REN_DIS:        dec_idx = CTR_REN_DIS;
      `PERF_ADDR_IQ_REG_READ:    dec_idx = CTR_IQ_REG_READ;
      `PERF_ADDR_FETCH1_STALL:   dec_idx = CTR_FETCH1_STALL;
      `PERF_ADDR_FREELIST_STALL: dec_idx = CTR_FREELIST_STALL;
      `PERF_ADDR_IQ_STALL:       dec_idx = CTR_IQ_STALL;
      `PERF_ADDR_ROB_STALL:      dec_idx = CTR_ROB_STALL;
      `PERF_ADDR_INST_MISS:      dec_idx = CTR_INST_MISS;
      `PERF_ADDR_LOAD_MISS:      dec_idx = CTR_LOAD_MISS;
      `PERF_ADDR_STORE_MISS:     dec_idx = CTR_STORE_MISS;
      default:                   dec_valid = 1'b0;
    endcase
  end

  // controls travel with their own cycle's events
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ev_o.incr       <= '0;
      ev_o.run        <= 1'b0;
      ev_o.global_clr <= 1'b0;
      ev_o.clr_hit    <= 1'b0;
      ev_o.sel_idx    <= CTR_CYCLES;
      ev_o.sel_valid  <= 1'b0;
    end
    else
    begin
      ev_o.incr       <= incr_d;
      ev_o.run        <= run_i;
      ev_o.global_clr <= global_clr_i;
      ev_o.clr_hit    <= clr_i & dec_valid;
      ev_o.sel_idx    <= dec_idx;
      ev_o.sel_valid  <= dec_valid;
    end
  end

endmodule

// File: src/perf_counter_bank.sv
module perf_counter_bank import perf_mon_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  perf_event_if.bank  ev_i,
  output perf_ctr_t   ctrs_o [NUM_CTRS]
);

  ////////////////////////////////////////////////////////////////////////////
  // counter update
  ////////////////////////////////////////////////////////////////////////////

  // global clear wins over run, nothing moves while run is low
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < NUM_CTRS; i++)
      begin
        ctrs_o[i] <= '0;
      end
    end
    else if (ev_i.global_clr)
    begin
      for (int i = 0; i < NUM_CTRS; i++)
      begin
        ctrs_o[i] <= '0;
      end
    end
    else if (ev_i.run)
    begin
      for (int i = 0; i < NUM_CTRS; i++)
      begin
        // addressed clear replaces this cycle's increment
        if (ev_i.clr_hit && (int'(ev_i.sel_idx) == i))
        begin
          ctrs_o[i] <= '0;
        end
        else
        begin
          // wraps on overflow
          ctrs_o[i] <= ctrs_o[i] + perf_ctr_t'(ev_i.incr[i]);
        end
      end
    end
  end

endmodule

// File: src/perf_readout.sv
`include "perf_mon_settings.svh"

module perf_readout import perf_mon_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  perf_ctr_t     ctrs_i [NUM_CTRS],
  perf_event_if.reader  sel_i,
  output perf_ctr_t     data_o
);

  perf_ctr_idx_t sel_idx_q;
  logic          sel_valid_q;

  // hold the select for one cycle so it lines up with the bank update
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sel_idx_q   <= CTR_CYCLES;
      sel_valid_q <= 1'b0;
    end
    else
    begin
      sel_idx_q   <= sel_i.sel_idx;
      sel_valid_q <= sel_i.sel_valid;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read port
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      data_o <= '0;
    end
    else if (sel_valid_q)
    begin
      data_o <= ctrs_i[sel_idx_q];
    end
    else
    begin
      data_o <= perf_ctr_t'(`PERF_UNMAPPED_DATA);
    end
  end

endmodule

// File: src/perf_mon_top.sv
`include "perf_mon_settings.svh"

module perf_mon_top import perf_mon_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic [`PERF_ADDR_WIDTH-1:0] addr_i,
  input  logic                        run_i,
  input  logic                        clr_i,
  input  logic                        global_clr_i,
  input  commit_lanes_t               commit_store_i,
  input  commit_lanes_t               commit_load_i,
  input  commit_lanes_t               total_commit_i,
  input  fetch_lanes_t                fs1_fs2_valid_i,
  input  fetch_lanes_t                fs2_dec_valid_i,
  input  dispatch_lanes_t             ren_dis_valid_i,
  input  issue_lanes_t                iq_reg_read_valid_i,
  input  logic                        recover_i,
  input  logic                        load_violation_i,
  input  logic                        fetch1_stall_i,
  input  logic                        freelist_stall_i,
  input  logic                        iq_stall_i,
  input  logic                        rob_stall_i,
  input  logic                        inst_miss_i,
  input  logic                        load_miss_i,
  input  logic                        store_miss_i,
  output perf_ctr_t                   data_o
);

  perf_ctr_t ctrs [NUM_CTRS];

  perf_event_if ev_if ();

  ////////////////////////////////////////////////////////////////////////////
  // sample, count, read
  ////////////////////////////////////////////////////////////////////////////
  perf_event_sampler u_sampler
  (
    .clk                 (clk),
    .reset               (reset),
    .addr_i              (addr_i),
    .run_i               (run_i),
    .clr_i               (clr_i),
    .global_clr_i        (global_clr_i),
    .commit_store_i      (commit_store_i),
    .commit_load_i       (commit_load_i),
    .total_commit_i      (total_commit_i),
    .fs1_fs2_valid_i     (fs1_fs2_valid_i),
    .fs2_dec_valid_i     (fs2_dec_valid_i),
    .ren_dis_valid_i     (ren_dis_valid_i),
    .iq_reg_read_valid_i (iq_reg_read_valid_i),
    .recover_i           (recover_i),
    .load_violation_i    (load_violation_i),
    .fetch1_stall_i      (fetch1_stall_i),
    .freelist_stall_i    (freelist_stall_i),
    .iq_stall_i          (iq_stall_i),
    .rob_stall_i         (rob_stall_i),
    .inst_miss_i         (inst_miss_i),
    .load_miss_i         (load_miss_i),
    .store_miss_i        (store_miss_i),
    .ev_o                (ev_if.sampler)
  );

  perf_counter_bank u_bank
  (
    .clk    (clk),
    .reset  (reset),
    .ev_i   (ev_if.bank),
    .ctrs_o (ctrs)
  );

  perf_readout u_readout
  (
    .clk    (clk),
    .reset  (reset),
    .ctrs_i (ctrs),
    .sel_i  (ev_if.reader),
    .data_o (data_o)
  );

endmodule

// File: testbench/perf_mon_tb.sv
`include "perf_mon_settings.svh"

module perf_mon_tb import perf_mon_pkg::*;
();

  localparam logic [1:0] NO_CLR     = 2'd0;
  localparam logic [1:0] ADDR_CLR   = 2'd1;
  localparam logic [1:0] GLOBAL_CLR = 2'd2;

  // address sampled at the first edge, data_o valid after two more
  localparam int READ_EDGES = 3;
  localparam int WAIT_LIMIT = 64;

  typedef struct packed
  {
    logic [7:0]      cycles;
    logic [1:0]      clr_mode;
    logic [7:0]      clr_addr;
    commit_lanes_t   cs;
    commit_lanes_t   cl;
    commit_lanes_t   tc;
    fetch_lanes_t    f12;
    fetch_lanes_t    f2d;
    dispatch_lanes_t rd;
    issue_lanes_t    iq;
    logic [8:0]      events;
    logic [7:0]      rd_addr;
    perf_ctr_t       expected;
    logic            rand_lanes;
  } row_t;

  logic                        clk;
  logic                        reset;
  logic [`PERF_ADDR_WIDTH-1:0] addr_i;
  logic                        run_i;
  logic                        clr_i;
  logic                        global_clr_i;
  commit_lanes_t               commit_store_i;
  commit_lanes_t               commit_load_i;
  commit_lanes_t               total_commit_i;
  fetch_lanes_t                fs1_fs2_valid_i;
  fetch_lanes_t                fs2_dec_valid_i;
  dispatch_lanes_t             ren_dis_valid_i;
  issue_lanes_t                iq_reg_read_valid_i;
  logic                        recover_i;
  logic                        load_violation_i;
  logic                        fetch1_stall_i;
  logic                        freelist_stall_i;
  logic                        iq_stall_i;
  logic                        rob_stall_i;
  logic                        inst_miss_i;
  logic                        load_miss_i;
  logic                        store_miss_i;
  perf_ctr_t                   data_o;

  row_t   rows[$];
  string  names[$];
  integer seed = 20;
  int     test_errs = 0;
  int     pass_count = 0;
  int     fail_count = 0;
  logic   timed_out = 1'b0;

  logic [7:0] mapped_addrs [17] = '{
    `PERF_ADDR_CYCLES, `PERF_ADDR_COMMIT_STORE, `PERF_ADDR_COMMIT_LOAD,
    `PERF_ADDR_RECOVER, `PERF_ADDR_LOAD_VIOL, `PERF_ADDR_TOTAL_COMMIT,
    `PERF_ADDR_FS1_FS2, `PERF_ADDR_FS2_DEC, `PERF_ADDR_REN_DIS,
    `PERF_ADDR_IQ_REG_READ, `PERF_ADDR_FETCH1_STALL, `PERF_ADDR_FREELIST_STALL,
    `PERF_ADDR_IQ_STALL, `PERF_ADDR_ROB_STALL, `PERF_ADDR_INST_MISS,
    `PERF_ADDR_LOAD_MISS, `PERF_ADDR_STORE_MISS
  };

  perf_mon_top uut
  (
    .clk                 (clk),
    .reset               (reset),
    .addr_i              (addr_i),
    .run_i               (run_i),
    .clr_i               (clr_i),
    .global_clr_i        (global_clr_i),
    .commit_store_i      (commit_store_i),
    .commit_load_i       (commit_load_i),
    .total_commit_i      (total_commit_i),
    .fs1_fs2_valid_i     (fs1_fs2_valid_i),
    .fs2_dec_valid_i     (fs2_dec_valid_i),
    .ren_dis_valid_i     (ren_dis_valid_i),
    .iq_reg_read_valid_i (iq_reg_read_valid_i),
    .recover_i           (recover_i),
    .load_violation_i    (load_violation_i),
    .fetch1_stall_i      (fetch1_stall_i),
    .freelist_stall_i    (freelist_stall_i),
    .iq_stall_i          (iq_stall_i),
    .rob_stall_i         (rob_stall_i),
    .inst_miss_i         (inst_miss_i),
    .load_miss_i         (load_miss_i),
    .store_miss_i        (store_miss_i),
    .data_o              (data_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // returns 2 units after the last edge, where inputs are driven
  task automatic wait_cycles(input int n);
    int waited;
    waited = 0;
    while (waited < n && !timed_out)
    begin
      if (waited >= WAIT_LIMIT)
      begin
        $display("timeout: waited more than %0d clock cycles", WAIT_LIMIT);
        timed_out = 1'b1;
      end
      else
      begin
        @(posedge clk);
        waited++;
      end
    end
    #2;
  endtask

  task automatic add_test(input string name, input int cycles, input logic [1:0] clr_mode,
                          input logic [7:0] clr_addr, input commit_lanes_t cs,
                          input commit_lanes_t cl, input commit_lanes_t tc,
                          input fetch_lanes_t f12, input fetch_lanes_t f2d,
                          input dispatch_lanes_t rd, input issue_lanes_t iq,
                          input logic [8:0] events, input logic [7:0] rd_addr,
                          input perf_ctr_t expected, input logic rand_lanes);
    row_t r;
    r.cycles     = 8'(cycles);
    r.clr_mode   = clr_mode;
    r.clr_addr   = clr_addr;
    r.cs         = cs;
    r.cl         = cl;
    r.tc         = tc;
    r.f12        = f12;
    r.f2d        = f2d;
    r.rd         = rd;
    r.iq         = iq;
    r.events     = events;
    r.rd_addr    = rd_addr;
    r.expected   = expected;
    r.rand_lanes = rand_lanes;
    rows.push_back(r);
    names.push_back(name);
  endtask

  // lane count per cycle for the vector behind a read address
  function automatic int set_bits_for_addr(input row_t r);
    case (r.rd_addr)
      `PERF_ADDR_COMMIT_STORE: return $countones(r.cs);
      `PERF_ADDR_COMMIT_LOAD:  return $countones(r.cl);
      `PERF_ADDR_TOTAL_COMMIT: return $countones(r.tc);
      `PERF_ADDR_FS1_FS2:      return $countones(r.f12);
      `PERF_ADDR_FS2_DEC:      return $countones(r.f2d);
      `PERF_ADDR_REN_DIS:      return $countones(r.rd);
      `PERF_ADDR_IQ_REG_READ:  return $countones(r.iq);
      default:                 return 0;
    endcase
  endfunction

  task automatic check_ctr(input string name, input perf_ctr_t expected,
                           input perf_ctr_t actual);
    if (actual !== expected)
    begin
      $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      test_errs++;
    end
  endtask

  task automatic check_idle_zero(input string name, input perf_ctr_t actual);
    if (actual !== '0)
    begin
      $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, perf_ctr_t'(0), actual);
      test_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0)
    begin
      $display("PASS %s", name);
      pass_count++;
    end
    else
    begin
      $display("FAIL %s", name);
      fail_count++;
    end
    test_errs = 0;
  endtask

  // run low during the read, so events still on the inputs must not count
  task automatic read_ctr(input logic [7:0] addr, output perf_ctr_t value);
    run_i        = 1'b0;
    clr_i        = 1'b0;
    global_clr_i = 1'b0;
    addr_i       = addr;
    wait_cycles(READ_EDGES);
    value = data_o;
  endtask

  task automatic run_row(input row_t r);
    global_clr_i = 1'b1;
    run_i        = 1'b0;
    wait_cycles(1);
    global_clr_i        = 1'b0;
    addr_i              = r.clr_addr;
    commit_store_i      = r.cs;
    commit_load_i       = r.cl;
    total_commit_i      = r.tc;
    fs1_fs2_valid_i     = r.f12;
    fs2_dec_valid_i     = r.f2d;
    ren_dis_valid_i     = r.rd;
    iq_reg_read_valid_i = r.iq;
    recover_i           = r.events[0];
    load_violation_i    = r.events[1];
    fetch1_stall_i      = r.events[2];
    freelist_stall_i    = r.events[3];
    iq_stall_i          = r.events[4];
    rob_stall_i         = r.events[5];
    inst_miss_i         = r.events[6];
    load_miss_i         = r.events[7];
    store_miss_i        = r.events[8];
    for (int c = 0; c < r.cycles; c++)
    begin
      run_i        = 1'b1;
      // clears ride on the last run cycle
      clr_i        = (r.clr_mode == ADDR_CLR) && (c == r.cycles - 1);
      global_clr_i = (r.clr_mode == GLOBAL_CLR) && (c == r.cycles - 1);
      wait_cycles(1);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test table
  ////////////////////////////////////////////////////////////////////////////
  initial
  begin
    add_test("cycles_7", 7, NO_CLR, 8'h00, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 5'h00,
             9'h000, `PERF_ADDR_CYCLES, 7, 1'b0);
    add_test("cycles_12", 12, NO_CLR, 8'h00, 4'hF, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 5'h00,
             9'h1FF, `PERF_ADDR_CYCLES, 12, 1'b0);
    add_test("commit_store", 5, NO_CLR, 8'h00, 4'hB, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 5'h00,
             9'h000, `PERF_ADDR_COMMIT_STORE, 15, 1'b0);
    add_test("commit_load", 6, NO_CLR, 8'h00, 4'h0, 4'h6, 4'h0, 4'h0, 4'h0, 4'h0, 5'h00,
             9'h000, `PERF_ADDR_COMMIT_LOAD, 12, 1'b0);
    add_test("total_commit", 4, NO_CLR, 8'h00, 4'h0, 4'h0, 4'hF, 4'h0, 4'h0, 4'h0, 5'h00,
             9'h000, `PERF_ADDR_TOTAL_COMMIT, 16, 1'b0);
    add_test("fs1_fs2_lanes", 9, NO_CLR, 8'h00, 4'h0, 4'h0, 4'h0, 4'h5, 4'h0, 4'h0, 5'h00,
             9'h000, `PERF_ADDR_FS1_FS2, 18, 1'b0);
    add_test("fs2_dec_lanes", 3, NO_CLR, 8'h00, 4'h0, 4'h0, 4'h0, 4'h0, 4'hE, 4'h0, 5'h00,
             9'h000, `PERF_ADDR_FS2_DEC, 9, 1'b0);
    add_test("ren_dis_lanes", 10, NO_CLR, 8'h00, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h8, 5'h00,
             9'h000, `PERF_ADDR_REN_DIS, 10, 1'b0);
    add_test("iq_rr_lanes", 8, NO_CLR, 8'h00, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 5'h1F,
             9'h000, `PERF_ADDR_IQ_REG_READ, 40, 1'b0);
    add_test("recover", 6, NO_CLR, 8'h00, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 5'h00,
             9'h001, `PERF_ADDR_RECOVER, 6, 1'b0);
    add_test("load_violation", 4, NO_CLR, 8'h00, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 5'h00,
             9'h1FF, `PERF_ADDR_LOAD_VIOL, 4, 1'b0);
    add_test("fetch1_stall", 5, NO_CLR, 8'h00, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 5'h00,
             9'h004, `PERF_ADDR_FETCH1_STALL, 5, 1'b0);
    add_test("freelist_stall", 7, NO_CLR, 8'h00, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 5'h00,
             9'h1FF, `PERF_ADDR_FREELIST_STALL, 7, 1'b0);
    add_test("iq_stall", 3, NO_CLR, 8'h00, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 5'h00,
             9'h010, `PERF_ADDR_IQ_STALL, 3, 1'b0);
    add_test("rob_stall", 11, NO_CLR, 8'h00, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 5'h00,
             9'h1FF, `PERF_ADDR_ROB_STALL, 11, 1'b0);
    add_test("inst_miss", 6, NO_CLR, 8'h00, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 5'h00,
             9'h040, `PERF_ADDR_INST_MISS, 6, 1'b0);
    add_test("load_miss", 2, NO_CLR, 8'h00, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 5'h00,
             9'h1FF, `PERF_ADDR_LOAD_MISS, 2, 1'b0);
    add_test("store_miss", 5, NO_CLR, 8'h00, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 5'h00,
             9'h100, `PERF_ADDR_STORE_MISS, 5, 1'b0);
    add_test("store_miss_low", 9, NO_CLR, 8'h00, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 5'h00,
             9'h0FF, `PERF_ADDR_STORE_MISS, 0, 1'b0);
    add_test("rand_commit_load", 13, NO_CLR, 8'h00, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0,
             5'h00, 9'h000, `PERF_ADDR_COMMIT_LOAD, 0, 1'b1);
    add_test("rand_iq_rr", 10, NO_CLR, 8'h00, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 5'h00,
             9'h000, `PERF_ADDR_IQ_REG_READ, 0, 1'b1);
    add_test("rand_fs2_dec", 7, NO_CLR, 8'h00, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 5'h00,
             9'h000, `PERF_ADDR_FS2_DEC, 0, 1'b1);
    add_test("rand_ren_dis", 6, NO_CLR, 8'h00, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 5'h00,
             9'h000, `PERF_ADDR_REN_DIS, 0, 1'b1);
    add_test("addr_clr_hit", 8, ADDR_CLR, 8'h01, 4'hF, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 5'h00,
             9'h000, `PERF_ADDR_COMMIT_STORE, 0, 1'b0);
    add_test("addr_clr_cycles", 8, ADDR_CLR, 8'h01, 4'hF, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0,
             5'h00, 9'h000, `PERF_ADDR_CYCLES, 8, 1'b0);
    add_test("addr_clr_keep", 8, ADDR_CLR, 8'h01, 4'hF, 4'h0, 4'h3, 4'h0, 4'h0, 4'h0, 5'h00,
             9'h000, `PERF_ADDR_TOTAL_COMMIT, 16, 1'b0);
    add_test("global_clr_cycles", 8, GLOBAL_CLR, 8'h00, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0,
             5'h00, 9'h1FF, `PERF_ADDR_CYCLES, 0, 1'b0);
    add_test("global_clr_lanes", 8, GLOBAL_CLR, 8'h00, 4'h0, 4'h0, 4'h0, 4'hF, 4'h0, 4'h0,
             5'h00, 9'h000, `PERF_ADDR_FS1_FS2, 0, 1'b0);
    add_test("unmapped_20", 4, NO_CLR, 8'h00, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 5'h00,
             9'h000, 8'h20, perf_ctr_t'('h55), 1'b0);
    add_test("unmapped_ff", 4, NO_CLR, 8'h00, 4'hF, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 5'h00,
             9'h1FF, 8'hFF, perf_ctr_t'('h55), 1'b0);
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial
  begin
    row_t      r;
    perf_ctr_t got;
    reset               = 1'b1;
    addr_i              = '0;
    run_i               = 1'b0;
    clr_i               = 1'b0;
    global_clr_i        = 1'b0;
    commit_store_i      = '0;
    commit_load_i       = '0;
    total_commit_i      = '0;
    fs1_fs2_valid_i     = '0;
    fs2_dec_valid_i     = '0;
    ren_dis_valid_i     = '0;
    iq_reg_read_valid_i = '0;
    recover_i           = 1'b0;
    load_violation_i    = 1'b0;
    fetch1_stall_i      = 1'b0;
    freelist_stall_i    = 1'b0;
    iq_stall_i          = 1'b0;
    rob_stall_i         = 1'b0;
    inst_miss_i         = 1'b0;
    load_miss_i         = 1'b0;
    store_miss_i        = 1'b0;
    wait_cycles(5);
    reset = 1'b0;

    check_idle_zero("reset_data_o", data_o);
    for (int a = 0; a < 17; a++)
    begin
      read_ctr(mapped_addrs[a], got);
      check_idle_zero($sformatf("reset_read_%02h", mapped_addrs[a]), got);
    end
    finish_test("reset_state");

    for (int i = 0; i < rows.size() && !timed_out; i++)
    begin
      r = rows[i];
      if (r.rand_lanes)
      begin
        r.cs       = commit_lanes_t'($random(seed));
        r.cl       = commit_lanes_t'($random(seed));
        r.tc       = commit_lanes_t'($random(seed));
        r.f12      = fetch_lanes_t'($random(seed));
        r.f2d      = fetch_lanes_t'($random(seed));
        r.rd       = dispatch_lanes_t'($random(seed));
        r.iq       = issue_lanes_t'($random(seed));
        r.expected = perf_ctr_t'(set_bits_for_addr(r) * r.cycles);
      end
      run_row(r);
      read_ctr(r.rd_addr, got);
      check_ctr(names[i], r.expected, got);
      finish_test(names[i]);
    end

    $display("tests: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0 && !timed_out)
    begin
      $display("SIMULATION PASSED");
    end
    else
    begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+include
src/perf_mon_pkg.sv
src/perf_event_if.sv
src/perf_event_sampler.sv
src/perf_counter_bank.sv
src/perf_readout.sv
src/perf_mon_top.sv
testbench/perf_mon_tb.sv
